/* hw/mips_config.svh */
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// data path and instruction word width.
`define XLEN 32

// register file address width, giving 32 registers.
`define REG_AW 5

// first fetch address after reset.
`define RESET_PC 0

// byte distance between consecutive instructions.
`define PC_STEP 4

`endif

/* hw/isa_pkg.sv */
`default_nettype none

`include "mips_config.svh"

package isa_pkg;

    // primary opcodes of the supported subset.
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_ADDI  = 6'h08,
        OP_ANDI  = 6'h0c,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_e;

    // function codes used by R-type instructions.
    typedef enum logic [5:0] {
        F_ADD = 6'h20,
        F_SUB = 6'h22,
        F_AND = 6'h24,
        F_OR  = 6'h25,
        F_SLT = 6'h2a
    } funct_e;

    // the immediate is bits 15:0 and the jump target bits 25:0 of this word.
    typedef struct packed {
        opcode_e               opcode;
        logic [`REG_AW-1:0]    rs;
        logic [`REG_AW-1:0]    rt;
        logic [`REG_AW-1:0]    rd;
        logic [4:0]            shamt;
        funct_e                funct;
    } instr_t;

endpackage

`default_nettype wire

/* hw/core_pkg.sv */
`default_nettype none

`include "mips_config.svh"

package core_pkg;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4
    } alu_op_e;

    // andi is the only instruction that zero extends.
    typedef enum logic {
        EXT_SIGN = 1'b0,
        EXT_ZERO = 1'b1
    } ext_mode_e;

    typedef struct packed {
        logic                  alu_src_imm;
        logic                  mem_read;
        logic                  mem_write;
        logic                  mem_to_reg;
        logic                  reg_write;
        logic [`REG_AW-1:0]    reg_dst;
        logic                  branch;
        logic                  jump;
        ext_mode_e             ext_mode;
        alu_op_e               alu_op;
        logic                  illegal;
    } ctrl_t;

    // only one instruction is in flight and only lw and sw reach S_MEM.
    typedef enum logic [1:0] {
        S_FETCH = 2'd0,
        S_EXEC  = 2'd1,
        S_MEM   = 2'd2
    } seq_state_e;

endpackage

`default_nettype wire

/* hw/control_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module control_unit
    import isa_pkg::*;
    import core_pkg::*;
(
    input  instr_t i_instr,
    output ctrl_t  o_ctrl
);

    always_comb begin
        o_ctrl.alu_src_imm = 1'b0;
        o_ctrl.mem_read    = 1'b0;
        o_ctrl.mem_write   = 1'b0;
        o_ctrl.mem_to_reg  = 1'b0;
        o_ctrl.reg_write   = 1'b0;
        o_ctrl.reg_dst     = '0;
        o_ctrl.branch      = 1'b0;
        o_ctrl.jump        = 1'b0;
        o_ctrl.ext_mode    = EXT_SIGN;
        o_ctrl.alu_op      = ALU_ADD;
        o_ctrl.illegal     = 1'b0;

        case (i_instr.opcode)
            OP_RTYPE: begin
                o_ctrl.reg_write = 1'b1;
                o_ctrl.reg_dst   = i_instr.rd;
                case (i_instr.funct)
                    F_ADD:   o_ctrl.alu_op = ALU_ADD;
                    F_SUB:   o_ctrl.alu_op = ALU_SUB;
                    F_AND:   o_ctrl.alu_op = ALU_AND;
                    F_OR:    o_ctrl.alu_op = ALU_OR;
                    F_SLT:   o_ctrl.alu_op = ALU_SLT;
                    default: begin
                        o_ctrl.reg_write = 1'b0;
                        o_ctrl.illegal   = 1'b1;
                    end
                endcase
            end
            OP_ADDI: begin
                o_ctrl.alu_src_imm = 1'b1;
                o_ctrl.reg_write   = 1'b1;
                o_ctrl.reg_dst     = i_instr.rt;
            end
            OP_ANDI: begin
                o_ctrl.alu_src_imm = 1'b1;
                o_ctrl.reg_write   = 1'b1;
                o_ctrl.reg_dst     = i_instr.rt;
                o_ctrl.ext_mode    = EXT_ZERO;
                o_ctrl.alu_op      = ALU_AND;
            end
            OP_BEQ: begin
                // the subtract result is only used for its zero flag.
                o_ctrl.branch = 1'b1;
                o_ctrl.alu_op = ALU_SUB;
            end
            OP_J: begin
                o_ctrl.jump = 1'b1;
            end
            OP_LW: begin
                o_ctrl.alu_src_imm = 1'b1;
                o_ctrl.mem_read    = 1'b1;
                o_ctrl.mem_to_reg  = 1'b1;
                o_ctrl.reg_write   = 1'b1;
                o_ctrl.reg_dst     = i_instr.rt;
            end
            OP_SW: begin
                o_ctrl.alu_src_imm = 1'b1;
                o_ctrl.mem_write   = 1'b1;
            end
            default: begin
                o_ctrl.illegal = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hw/alu.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mips_config.svh"

module alu
    import core_pkg::*;
(
    input  alu_op_e            i_op,
    input  logic [`XLEN-1:0]   i_a,
    input  logic [`XLEN-1:0]   i_b,
    output logic [`XLEN-1:0]   o_result,
    output logic               o_zero
);

    always_comb begin
        case (i_op)
            ALU_ADD: o_result = i_a + i_b;
            ALU_SUB: o_result = i_a - i_b;
            ALU_AND: o_result = i_a & i_b;
            ALU_OR:  o_result = i_a | i_b;
            // slt compares as two's complement.
            ALU_SLT: o_result = {{(`XLEN-1){1'b0}}, $signed(i_a) < $signed(i_b)};
            default: o_result = '0;
        endcase
    end

    assign o_zero = (o_result == '0);

endmodule

`default_nettype wire

/* hw/reg_file.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mips_config.svh"

module reg_file (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_we,
    input  logic [`REG_AW-1:0]   i_waddr,
    input  logic [`XLEN-1:0]     i_wdata,
    input  logic [`REG_AW-1:0]   i_raddr_a,
    input  logic [`REG_AW-1:0]   i_raddr_b,
    output logic [`XLEN-1:0]     o_rdata_a,
    output logic [`XLEN-1:0]     o_rdata_b
);

    logic [`XLEN-1:0] regs [2**`REG_AW];

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 2**`REG_AW; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_waddr != '0)) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    assign o_rdata_a = regs[i_raddr_a];
    assign o_rdata_b = regs[i_raddr_b];

    // register zero must survive any write aimed at it.
    a_zero_reg: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_raddr_a == '0) |-> (o_rdata_a == '0));

endmodule

`default_nettype wire

/* hw/core_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module core_sequencer
    import core_pkg::*;
(
    input  logic  i_clk,
    input  logic  i_rst_n,
    input  ctrl_t i_ctrl,
    input  logic  i_wb_ack,
    output logic  o_ifetch,
    output logic  o_ir_load,
    output logic  o_reg_we,
    output logic  o_pc_we,
    output logic  o_wb_cyc,
    output logic  o_wb_stb,
    output logic  o_wb_we
);

    seq_state_e state_q;
    seq_state_e state_d;
    logic       is_mem;

    assign is_mem = i_ctrl.mem_read | i_ctrl.mem_write;

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_FETCH: state_d = S_EXEC;
            S_EXEC:  state_d = is_mem ? S_MEM : S_FETCH;
            S_MEM:   state_d = i_wb_ack ? S_FETCH : S_MEM;
            default: state_d = S_FETCH;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state_q <= S_FETCH;
        end else begin
            state_q <= state_d;
        end
    end

    assign o_ifetch  = (state_q == S_FETCH);
    assign o_ir_load = (state_q == S_FETCH);

    // an instruction ends either in S_EXEC or on the ack of its bus cycle.
    assign o_reg_we = i_ctrl.reg_write &
                      (((state_q == S_EXEC) & ~is_mem) |
                       ((state_q == S_MEM) & i_wb_ack & i_ctrl.mem_read));
    assign o_pc_we  = ((state_q == S_EXEC) & ~is_mem) |
                      ((state_q == S_MEM) & i_wb_ack);

    assign o_wb_cyc = (state_q == S_MEM);
    assign o_wb_stb = (state_q == S_MEM);
    assign o_wb_we  = (state_q == S_MEM) & i_ctrl.mem_write;

    a_stb_in_cyc: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_wb_stb |-> o_wb_cyc);

    a_we_in_cyc: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_wb_we |-> o_wb_cyc);

    a_mem_until_ack: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        ((state_q == S_MEM) && !i_wb_ack) |=> (state_q == S_MEM));

    // an undecodable instruction retires without a register write or a bus cycle.
    a_illegal_nop: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        ((state_q == S_EXEC) && i_ctrl.illegal) |-> (!o_reg_we && !is_mem));

endmodule

`default_nettype wire

/* hw/mips_core.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mips_config.svh"

module mips_core
    import isa_pkg::*;
    import core_pkg::*;
(
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic [`XLEN-1:0]   i_instr,
    input  logic               i_wb_ack,
    input  logic [`XLEN-1:0]   i_wb_dat,
    output logic [`XLEN-1:0]   o_pc,
    output logic               o_ifetch,
    output logic               o_wb_cyc,
    output logic               o_wb_stb,
    output logic               o_wb_we,
    output logic [`XLEN-1:0]   o_wb_adr,
    output logic [`XLEN-1:0]   o_wb_dat
);

    logic [`XLEN-1:0] pc_q;
    logic [`XLEN-1:0] pc_next;
    logic [`XLEN-1:0] pc_plus4;
    logic [`XLEN-1:0] branch_target;
    instr_t           ir_q;
    ctrl_t            ctrl;
    logic             ir_load;
    logic             reg_we;
    logic             pc_we;
    logic [`XLEN-1:0] rdata_a;
    logic [`XLEN-1:0] rdata_b;
    logic [`XLEN-1:0] imm_ext;
    logic [`XLEN-1:0] alu_b;
    logic [`XLEN-1:0] alu_result;
    logic             alu_zero;
    logic [`XLEN-1:0] wb_data;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            pc_q <= `XLEN'(`RESET_PC);
        end else if (pc_we) begin
            pc_q <= pc_next;
        end
    end

    always_ff @(posedge i_clk) begin
        if (ir_load) begin
            ir_q <= instr_t'(i_instr);
        end
    end

    control_unit u_control_unit (
        .i_instr (ir_q),
        .o_ctrl  (ctrl)
    );

    core_sequencer u_sequencer (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_ctrl    (ctrl),
        .i_wb_ack  (i_wb_ack),
        .o_ifetch  (o_ifetch),
        .o_ir_load (ir_load),
        .o_reg_we  (reg_we),
        .o_pc_we   (pc_we),
        .o_wb_cyc  (o_wb_cyc),
        .o_wb_stb  (o_wb_stb),
        .o_wb_we   (o_wb_we)
    );

    reg_file u_reg_file (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_we      (reg_we),
        .i_waddr   (ctrl.reg_dst),
        .i_wdata   (wb_data),
        .i_raddr_a (ir_q.rs),
        .i_raddr_b (ir_q.rt),
        .o_rdata_a (rdata_a),
        .o_rdata_b (rdata_b)
    );

    assign imm_ext = (ctrl.ext_mode == EXT_ZERO) ? {16'b0, ir_q[15:0]}
                                                 : {{16{ir_q[15]}}, ir_q[15:0]};
    assign alu_b   = ctrl.alu_src_imm ? imm_ext : rdata_b;

    alu u_alu (
        .i_op     (ctrl.alu_op),
        .i_a      (rdata_a),
        .i_b      (alu_b),
        .o_result (alu_result),
        .o_zero   (alu_zero)
    );

    // loads write the bus data straight into the register file on ack.
    assign wb_data = ctrl.mem_to_reg ? i_wb_dat : alu_result;

    // pc_q still holds the address of the executing instruction here.
    assign pc_plus4      = pc_q + `XLEN'(`PC_STEP);
    assign branch_target = pc_plus4 + {imm_ext[`XLEN-3:0], 2'b00};

    always_comb begin
        if (ctrl.jump) begin
            pc_next = {pc_plus4[31:28], ir_q[25:0], 2'b00};
        end else if (ctrl.branch && alu_zero) begin
            pc_next = branch_target;
        end else begin
            pc_next = pc_plus4;
        end
    end

    assign o_pc     = pc_q;
    assign o_wb_adr = alu_result;
    assign o_wb_dat = rdata_b;

    // a stalled bus cycle must present the same request until the slave acks.
    a_wb_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_wb_cyc && !i_wb_ack) |=>
            (o_wb_cyc && $stable(o_wb_adr) && $stable(o_wb_dat) && $stable(o_wb_we)));

endmodule

`default_nettype wire

/* tb/tb_ref_model.svh */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// architectural state of the reference model.
logic [`XLEN-1:0] m_regs [32];
logic [`XLEN-1:0] m_mem [64];
logic [`XLEN-1:0] m_pc;
bit               m_loaded [32];

// bus request expected from the instruction stepped last.
logic             exp_bus;
logic             exp_we;
logic [`XLEN-1:0] exp_adr;
logic [`XLEN-1:0] exp_dat;
bit               exp_dat_loaded;

task automatic model_reset();
    int k;
    begin
        for (k = 0; k < 32; k++) begin
            m_regs[k] = '0;
            m_loaded[k] = 1'b0;
        end
        for (k = 0; k < 64; k++) begin
            m_mem[k] = fill_word(k);
        end
        m_pc = `XLEN'(`RESET_PC);
        exp_bus = 1'b0;
        exp_we = 1'b0;
        exp_adr = '0;
        exp_dat = '0;
        exp_dat_loaded = 1'b0;
    end
endtask

task automatic model_step(input logic [`XLEN-1:0] word);
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_z;
    logic [`XLEN-1:0] res;
    logic [`XLEN-1:0] next_pc;
    logic [4:0]       dst;
    bit               wr;
    bit               ld;
    begin
        a = m_regs[word[25:21]];
        b = m_regs[word[20:16]];
        imm_s = {{16{word[15]}}, word[15:0]};
        imm_z = {16'h0000, word[15:0]};
        next_pc = m_pc + 32'd4;
        res = '0;
        dst = '0;
        wr = 1'b0;
        ld = 1'b0;
        exp_bus = 1'b0;
        exp_we = 1'b0;
        exp_adr = '0;
        exp_dat = '0;
        exp_dat_loaded = 1'b0;
        case (word[31:26])
            OP_RTYPE: begin
                dst = word[15:11];
                wr = 1'b1;
                case (word[5:0])
                    F_ADD:   res = a + b;
                    F_SUB:   res = a - b;
                    F_AND:   res = a & b;
                    F_OR:    res = a | b;
                    F_SLT:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: wr = 1'b0;
                endcase
            end
            OP_ADDI: begin
                res = a + imm_s;
                dst = word[20:16];
                wr = 1'b1;
            end
            OP_ANDI: begin
                res = a & imm_z;
                dst = word[20:16];
                wr = 1'b1;
            end
            OP_BEQ: begin
                if (a == b) begin
                    next_pc = next_pc + {imm_s[29:0], 2'b00};
                end
            end
            OP_J: begin
                next_pc = {next_pc[31:28], word[25:0], 2'b00};
            end
            OP_LW: begin
                exp_bus = 1'b1;
                exp_adr = a + imm_s;
                res = m_mem[exp_adr[7:2]];
                dst = word[20:16];
                wr = 1'b1;
                ld = 1'b1;
            end
            OP_SW: begin
                exp_bus = 1'b1;
                exp_we = 1'b1;
                exp_adr = a + imm_s;
                exp_dat = b;
                exp_dat_loaded = m_loaded[word[20:16]];
                m_mem[exp_adr[7:2]] = b;
            end
            default: begin
            end
        endcase
        if (wr && (dst != 5'd0)) begin
            m_regs[dst] = res;
            m_loaded[dst] = ld;
        end
        m_pc = next_pc;
    end
endtask

`endif

/* tb/tb_mips_core.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mips_config.svh"

module tb_mips_core
    import isa_pkg::*;
();

    localparam int RETIRE_LIMIT = 200;
    localparam int MAX_WAIT     = 3;
    localparam int MAX_CYCLES   = RETIRE_LIMIT * (3 + MAX_WAIT) + 64;

    logic             clk = 1'b0;
    logic             rst_n;
    logic [`XLEN-1:0] instr;
    logic             wb_ack;
    logic [`XLEN-1:0] wb_dat_s;
    logic [`XLEN-1:0] pc;
    logic             ifetch;
    logic             wb_cyc;
    logic             wb_stb;
    logic             wb_we;
    logic [`XLEN-1:0] wb_adr;
    logic [`XLEN-1:0] wb_dat_m;

    logic [`XLEN-1:0] prog [64];
    logic [`XLEN-1:0] slave_mem [64];
    logic [15:0]      lfsr_state;
    int               cycle_count = 0;
    int               retired;
    int               last_fetch;
    logic [`XLEN-1:0] last_pc;
    bit               done;
    bit               bus_started;
    bit               bus_done;
    int               wait_target;
    int               wait_count;
    logic [`XLEN-1:0] req_adr;
    logic             req_we;
    logic [`XLEN-1:0] req_dat;

    `include "tb_ref_model.svh"

    always #50 clk = ~clk;

    // the instruction port answers in the same cycle.
    assign instr = prog[pc[7:2]];

    mips_core dut (
        .i_clk    (clk),
        .i_rst_n  (rst_n),
        .i_instr  (instr),
        .i_wb_ack (wb_ack),
        .i_wb_dat (wb_dat_s),
        .o_pc     (pc),
        .o_ifetch (ifetch),
        .o_wb_cyc (wb_cyc),
        .o_wb_stb (wb_stb),
        .o_wb_we  (wb_we),
        .o_wb_adr (wb_adr),
        .o_wb_dat (wb_dat_m)
    );

    function automatic logic [`XLEN-1:0] take_bits(input int n);
        logic [`XLEN-1:0] v;
        int               k;
        begin
            v = '0;
            for (k = 0; k < n; k++) begin
                lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 16'hb400 : 16'h0000);
                v = {v[`XLEN-2:0], lfsr_state[0]};
            end
            return v;
        end
    endfunction

    function automatic logic [`XLEN-1:0] fill_word(input int idx);
        return 32'h5a3c_0000 ^ (32'(idx) * 32'h0001_0203);
    endfunction

    function automatic logic [4:0] pick_reg();
        return 5'(take_bits(3));
    endfunction

    function automatic logic [5:0] pick_funct();
        logic [`XLEN-1:0] r;
        begin
            r = take_bits(3) % 5;
            case (r)
                0:       return F_ADD;
                1:       return F_SUB;
                2:       return F_AND;
                3:       return F_OR;
                default: return F_SLT;
            endcase
        end
    endfunction

    function automatic logic [`XLEN-1:0] enc_r(input logic [5:0] funct, input logic [4:0] rs,
                                               input logic [4:0] rt, input logic [4:0] rd);
        return {OP_RTYPE, rs, rt, rd, 5'h00, funct};
    endfunction

    function automatic logic [`XLEN-1:0] enc_i(input opcode_e op, input logic [4:0] rs,
                                               input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [`XLEN-1:0] enc_j(input logic [25:0] target);
        return {OP_J, target};
    endfunction

    // control transfers are patched in after all memory slots are known.
    task automatic build_program();
        int               i;
        int               t;
        logic [4:0]       rs;
        logic [4:0]       rt;
        logic [4:0]       ra;
        logic [2:0]       kind;
        logic [`XLEN-1:0] r;
        bit               is_mem [64];
        bit               is_ctl [64];
        begin
            for (i = 0; i < 64; i++) begin
                is_mem[i] = 1'b0;
                is_ctl[i] = 1'b0;
                prog[i] = '0;
            end
            i = 0;
            while (i < 63) begin
                kind = 3'(take_bits(3));
                rs = pick_reg();
                rt = pick_reg();
                if ((kind == 3'd5 || kind == 3'd6) && i < 62) begin
                    // masking the base keeps the access word aligned inside the memory.
                    ra = pick_reg();
                    prog[i] = enc_i(OP_ANDI, rs, ra, 16'h00fc);
                    if (kind == 3'd5) begin
                        prog[i+1] = enc_i(OP_LW, ra, rt, 16'h0000);
                    end else begin
                        prog[i+1] = enc_i(OP_SW, ra, rt, 16'h0000);
                    end
                    is_mem[i+1] = 1'b1;
                    i += 2;
                end else begin
                    case (kind)
                        3'd0, 3'd7: prog[i] = enc_r(pick_funct(), rs, rt, pick_reg());
                        3'd2: prog[i] = enc_i(OP_ANDI, rs, rt, 16'(take_bits(16)));
                        3'd3, 3'd4: is_ctl[i] = 1'b1;
                        default: begin
                            r = take_bits(5);
                            prog[i] = enc_i(OP_ADDI, rs, rt, {{11{r[4]}}, r[4:0]});
                        end
                    endcase
                    i++;
                end
            end
            is_ctl[63] = 1'b1;
            for (i = 0; i < 64; i++) begin
                if (is_ctl[i]) begin
                    if (i == 63) begin
                        t = int'(take_bits(5));
                    end else begin
                        t = i + 1 + int'(take_bits(3));
                    end
                    if (t > 63) begin
                        t = 63;
                    end
                    while (is_mem[t]) begin
                        t++;
                    end
                    if (i == 63 || take_bits(1) != 0) begin
                        prog[i] = enc_j(26'(t));
                    end else begin
                        prog[i] = enc_i(OP_BEQ, pick_reg(), pick_reg(), 16'(t - i - 1));
                    end
                end
            end
        end
    endtask

    task automatic abort_run();
        $display("Verification failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [`XLEN-1:0] got,
                                   input logic [`XLEN-1:0] exp);
        $display("ERR %s got %h exp %h", name, got, exp);
        abort_run();
    endtask

    task automatic check_pc(input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] exp);
        if (got !== exp) begin
            report_mismatch("o_pc", got, exp);
        end
    endtask

    task automatic check_wb_req(input logic [`XLEN-1:0] adr, input logic we,
                                input logic [`XLEN-1:0] dat, input logic [`XLEN-1:0] e_adr,
                                input logic e_we, input logic [`XLEN-1:0] e_dat,
                                input bit cmp_dat);
        if (adr !== e_adr) begin
            report_mismatch("o_wb_adr", adr, e_adr);
        end
        if (we !== e_we) begin
            report_mismatch("o_wb_we", `XLEN'(we), `XLEN'(e_we));
        end
        if (cmp_dat && (dat !== e_dat)) begin
            report_mismatch("o_wb_dat", dat, e_dat);
        end
    endtask

    task automatic check_load(input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] exp);
        if (got !== exp) begin
            report_mismatch("o_wb_dat (stored load result)", got, exp);
        end
    endtask

    task automatic handle_fetch();
        int gap;
        int want;
        begin
            if (retired > 0) begin
                gap = cycle_count - last_fetch;
                want = exp_bus ? 3 + wait_target : 2;
                if (exp_bus && !bus_done) begin
                    $display("memory instruction at %h ended without a bus cycle", last_pc);
                    abort_run();
                end
                if (gap != want) begin
                    $display("instruction at %h took %0d cycles instead of %0d",
                             last_pc, gap, want);
                    abort_run();
                end
            end
            check_pc(pc, m_pc);
            if (retired == RETIRE_LIMIT) begin
                done = 1'b1;
            end else begin
                last_pc = m_pc;
                last_fetch = cycle_count;
                bus_started = 1'b0;
                bus_done = 1'b0;
                model_step(prog[m_pc[7:2]]);
                retired++;
            end
        end
    endtask

    task automatic serve_bus();
        if (!exp_bus || bus_done) begin
            $display("bus cycle open at %h where none was expected", wb_adr);
            abort_run();
        end
        if (!bus_started) begin
            bus_started = 1'b1;
            wait_target = int'(take_bits(2));
            wait_count = 0;
            check_wb_req(wb_adr, wb_we, wb_dat_m, exp_adr, exp_we, exp_dat,
                         exp_we && !exp_dat_loaded);
            if (exp_we && exp_dat_loaded) begin
                check_load(wb_dat_m, exp_dat);
            end
            req_adr = wb_adr;
            req_we = wb_we;
            req_dat = wb_dat_m;
        end else begin
            // request held while ack is withheld.
            check_wb_req(wb_adr, wb_we, wb_dat_m, req_adr, req_we, req_dat, 1'b1);
        end
        if (wait_count == wait_target) begin
            wb_ack = 1'b1;
            if (wb_we) begin
                slave_mem[wb_adr[7:2]] = wb_dat_m;
            end else begin
                wb_dat_s = slave_mem[wb_adr[7:2]];
            end
            bus_done = 1'b1;
        end else begin
            wait_count++;
        end
    endtask

    task automatic service_cycle();
        wb_ack = 1'b0;
        wb_dat_s = '0;
        if (!wb_cyc && (wb_stb || wb_we)) begin
            $display("o_wb_stb or o_wb_we is high outside a bus cycle");
            abort_run();
        end
        if (wb_cyc && (!wb_stb || ifetch)) begin
            $display("bus cycle without strobe, or overlapping an instruction fetch");
            abort_run();
        end
        if (ifetch) begin
            handle_fetch();
        end else if (wb_cyc) begin
            serve_bus();
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > MAX_CYCLES) begin
            $display("run did not complete %0d instructions within %0d cycles",
                     RETIRE_LIMIT, MAX_CYCLES);
            abort_run();
        end
    end

    initial begin
        int k;
        rst_n = 1'b0;
        wb_ack = 1'b0;
        wb_dat_s = '0;
        lfsr_state = 16'd24111;
        done = 1'b0;
        retired = 0;
        last_fetch = 0;
        last_pc = '0;
        bus_started = 1'b0;
        bus_done = 1'b0;
        wait_target = 0;
        wait_count = 0;
        build_program();
        for (k = 0; k < 64; k++) begin
            slave_mem[k] = fill_word(k);
        end
        model_reset();
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        service_cycle();
        while (!done) begin
            @(posedge clk);
            #1;
            service_cycle();
        end
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+hw
+incdir+tb
hw/isa_pkg.sv
hw/core_pkg.sv
hw/control_unit.sv
hw/alu.sv
hw/reg_file.sv
hw/core_sequencer.sv
hw/mips_core.sv
tb/tb_mips_core.sv
